// ==== project.f ====
hw/lcd_pkg.sv
hw/lcd_cmd_seq.sv
hw/hex_char_fmt.sv
hw/lcd_bus_ctrl.sv
hw/lcd_voltmeter_top.sv
test/lcd_bus_assert.sv
test/tb_lcd_voltmeter.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_lcd_voltmeter
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := NO ERRORS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_lcd_voltmeter.sv ====
`timescale 1ns/1ps

module tb_lcd_voltmeter;

    import lcd_pkg::*;

    localparam int N_ROWS     = 6;
    localparam int WAIT_LIMIT = 2000;           // Clocks before a wait gives up
    localparam int FRAME_LEN  = 1 + N_DIGITS;   // Home plus the digits

    logic                clk = 1'b0;
    logic                rst;
    logic                update;
    logic [SAMPLE_W-1:0] v_in;
    logic                busy = 1'b0;
    logic                rs;
    logic                e;
    logic [BYTE_W-1:0]   data;
    logic                lcd_ready;

    // Rows together hit every nibble value
    string row_name [N_ROWS] = '{
        "all_zero", "all_f", "count_up", "mixed_a5c3", "mixed_9e0b", "mixed_678d"
    };
    logic [SAMPLE_W-1:0] row_val [N_ROWS] = '{
        16'h0000, 16'hFFFF, 16'h1234, 16'hA5C3, 16'h9E0B, 16'h678D
    };

    logic [BYTE_W:0] rx_q [$];      // {rs, data} per written byte
    logic            e_prev;
    int              writes_seen;
    int              writes_done;
    int              busy_left;     // Busy cycles still to go
    integer          seed = 32'h99b7_e42e;
    int              errors;

    lcd_voltmeter_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .update    (update),
        .v_in      (v_in),
        .busy      (busy),
        .rs        (rs),
        .e         (e),
        .data      (data),
        .lcd_ready (lcd_ready)
    );

    always #20 clk = ~clk;

    // LCD model takes rs and data once e has fallen
    always @(negedge clk) begin
        if (e_prev === 1'b1 && e === 1'b0) begin
            rx_q.push_back({rs, data});
            writes_seen++;
        end
        e_prev = e;
    end

    // LCD stays busy 0 to 5 cycles after each write
    always @(posedge clk) begin
        if (writes_done != writes_seen) begin
            writes_done = writes_seen;
            busy_left   = $unsigned($random(seed)) % 6;
        end else if (busy_left != 0) begin
            busy_left--;
        end
        busy <= (busy_left != 0);
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic wait_ready(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (lcd_ready !== level) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout: lcd_ready never went to %0b during %s", level, what);
                $display("ERRORS FOUND");
                $fatal(1, "Wait timeout");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // 0-9 give digits, 10-15 give A-F
    function automatic logic [BYTE_W-1:0] hex_digit_ascii(input logic [NIBBLE_W-1:0] nib);
        if (nib > 4'd9) begin
            return ASCII_A + BYTE_W'(nib - 4'd10);
        end else begin
            return ASCII_ZERO + BYTE_W'(nib);
        end
    endfunction

    task automatic check_init();
        lcd_cmd_e        init_order [N_INIT_CMDS];
        logic [BYTE_W:0] got;
        int              i;
        init_order = '{cmd_function_set, cmd_display_on, cmd_entry_mode, cmd_clear};
        check_value("init count", 32'(N_INIT_CMDS), 32'(rx_q.size()));
        for (i = 0; i < N_INIT_CMDS; i++) begin
            got = rx_q.pop_front();
            check_value($sformatf("init cmd %0d", i), 32'({1'b0, init_order[i]}), 32'(got));
        end
    endtask

    task automatic check_frame(input string name, input logic [SAMPLE_W-1:0] val);
        logic [BYTE_W:0]   got;
        logic [NIBBLE_W-1:0] nib;
        int                i;
        check_value({name, " count"}, 32'(FRAME_LEN), 32'(rx_q.size()));
        got = rx_q.pop_front();
        check_value({name, " home"}, 32'({1'b0, cmd_home}), 32'(got));
        for (i = 0; i < N_DIGITS; i++) begin
            nib = val[SAMPLE_W-1-NIBBLE_W*i -: NIBBLE_W];   // MS nibble first
            got = rx_q.pop_front();
            check_value($sformatf("%s char %0d", name, i),
                        32'({1'b1, hex_digit_ascii(nib)}), 32'(got));
        end
    endtask

    initial begin
        int row;
        rst    = 1'b1;
        update = 1'b0;
        v_in   = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        wait_ready(1'b1, "init list");
        check_init();

        for (row = 0; row < N_ROWS; row++) begin
            wait_ready(1'b1, row_name[row]);
            @(posedge clk);
            update <= 1'b1;
            v_in   <= row_val[row];
            @(posedge clk);
            update <= 1'b0;
            v_in   <= ~row_val[row];    // Must not reach the display
            wait_ready(1'b0, row_name[row]);
            wait_ready(1'b1, row_name[row]);
            check_frame(row_name[row], row_val[row]);

            // Quiet bus without an update
            repeat (8) @(negedge clk);
            check_value({row_name[row], " idle"}, 32'd0, 32'(rx_q.size()));
        end

        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== test/lcd_bus_assert.sv ====
`timescale 1ns/1ps

module lcd_bus_assert #(
    parameter int E_PULSE_CYCLES = 4
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        update,
    input logic                        lcd_ready,
    input logic                        rs,
    input logic                        e,
    input logic [lcd_pkg::BYTE_W-1:0]  data
);

    int e_high_cnt;     // Clocks seen with e high in the current pulse

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            e_high_cnt <= 0;
        end else if (e) begin
            e_high_cnt <= e_high_cnt + 1;
        end else begin
            e_high_cnt <= 0;
        end
    end

    // Enable pulse has the programmed width
    a_e_width: assert property (@(posedge clk) disable iff (rst)
        $fell(e) |-> (e_high_cnt == E_PULSE_CYCLES))
        else $error("e pulse lasted %0d cycles", e_high_cnt);

    // Bus frozen while the LCD may be latching
    a_bus_stable: assert property (@(posedge clk) disable iff (rst)
        (e && $past(e)) |-> ($stable(rs) && $stable(data)))
        else $error("rs or data moved while e was high");

    a_update_ready: assert property (@(posedge clk) disable iff (rst)
        update |-> lcd_ready)
        else $error("update pulsed while the display was not ready");

endmodule

// The top level carries update next to the bus controller outputs
bind lcd_voltmeter_top lcd_bus_assert #(
    .E_PULSE_CYCLES (E_PULSE_CYCLES)
) i_bus_assert (
    .clk       (clk),
    .rst       (rst),
    .update    (update),
    .lcd_ready (lcd_ready),
    .rs        (rs),
    .e         (e),
    .data      (data)
);

// ==== hw/lcd_voltmeter_top.sv ====
`timescale 1ns/1ps

module lcd_voltmeter_top #(
    parameter int E_SETUP_CYCLES = 2,
    parameter int E_PULSE_CYCLES = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        update,
    input  logic [lcd_pkg::SAMPLE_W-1:0] v_in,
    input  logic                        busy,
    output logic                        rs,
    output logic                        e,
    output logic [lcd_pkg::BYTE_W-1:0]   data,
    output logic                        lcd_ready
);

    import lcd_pkg::*;

    // Command stream
    logic       cmd_valid;
    lcd_cmd_e   cmd_byte;
    logic       cmd_take;

    // Character stream
    logic              char_valid;
    logic [BYTE_W-1:0] char_byte;
    logic              char_take;

    lcd_cmd_seq i_cmd_seq (
        .clk       (clk),
        .rst       (rst),
        .update    (update),
        .cmd_take  (cmd_take),
        .cmd_valid (cmd_valid),
        .cmd_byte  (cmd_byte)
    );

    hex_char_fmt i_char_fmt (
        .clk        (clk),
        .rst        (rst),
        .update     (update),
        .sample     (v_in),
        .char_take  (char_take),
        .char_valid (char_valid),
        .char_byte  (char_byte)
    );

    lcd_bus_ctrl #(
        .E_SETUP_CYCLES (E_SETUP_CYCLES),
        .E_PULSE_CYCLES (E_PULSE_CYCLES)
    ) i_bus_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_byte   (cmd_byte),
        .char_valid (char_valid),
        .char_byte  (char_byte),
        .busy       (busy),
        .cmd_take   (cmd_take),
        .char_take  (char_take),
        .rs         (rs),
        .e          (e),
        .data       (data),
        .lcd_ready  (lcd_ready)
    );

endmodule

// ==== hw/lcd_bus_ctrl.sv ====
`timescale 1ns/1ps

module lcd_bus_ctrl #(
    parameter int E_SETUP_CYCLES = 2,
    parameter int E_PULSE_CYCLES = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_valid,
    input  lcd_pkg::lcd_cmd_e         cmd_byte,
    input  logic                      char_valid,
    input  logic [lcd_pkg::BYTE_W-1:0] char_byte,
    input  logic                      busy,
    output logic                      cmd_take,
    output logic                      char_take,
    output logic                      rs,
    output logic                      e,
    output logic [lcd_pkg::BYTE_W-1:0] data,
    output logic                      lcd_ready
);

    import lcd_pkg::*;

    localparam int CNT_MAX = (E_SETUP_CYCLES > E_PULSE_CYCLES) ? E_SETUP_CYCLES
                                                              : E_PULSE_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    bus_state_e       state;
    logic [CNT_W-1:0] cnt;      // Cycles left in setup or pulse

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
            rs    <= 1'b0;
            e     <= 1'b0;
            data  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // Commands always win over characters
                    if (cmd_valid) begin
                        rs    <= 1'b0;
                        data  <= cmd_byte;
                        state <= st_wait_busy;
                    end else if (char_valid) begin
                        rs    <= 1'b1;
                        data  <= char_byte;
                        state <= st_wait_busy;
                    end
                end
                st_wait_busy: begin
                    if (!busy) begin
                        cnt   <= CNT_W'(E_SETUP_CYCLES - 1);
                        state <= st_setup;
                    end
                end
                st_setup: begin
                    if (cnt == '0) begin
                        e     <= 1'b1;
                        cnt   <= CNT_W'(E_PULSE_CYCLES - 1);
                        state <= st_pulse;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                st_pulse: begin
                    if (cnt == '0) begin
                        e     <= 1'b0;    // LCD latches on this falling edge
                        state <= st_hold;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                st_hold: begin
                    state <= st_idle;
                end
                default: begin
                    e     <= 1'b0;
                    state <= st_idle;
                end
            endcase
        end
    end

    // Take in the hold cycle, so the stream has moved on by idle
    assign cmd_take  = (state == st_hold) && !rs;
    assign char_take = (state == st_hold) && rs;

    // One cycle behind the valids
    // stays high for one cycle after an update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lcd_ready <= 1'b0;
        end else begin
            lcd_ready <= (state == st_idle) && !cmd_valid && !char_valid;
        end
    end

endmodule

// ==== hw/hex_char_fmt.sv ====
`timescale 1ns/1ps

module hex_char_fmt (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        update,
    input  logic [lcd_pkg::SAMPLE_W-1:0] sample,
    input  logic                        char_take,
    output logic                        char_valid,
    output logic [lcd_pkg::BYTE_W-1:0]   char_byte
);

    import lcd_pkg::*;

    localparam int CNT_W = $clog2(N_DIGITS + 1);

    logic [SAMPLE_W-1:0] sample_sr;     // Captured sample with the next char in the top nibble
    logic [CNT_W-1:0]    digit_cnt;     // Characters still to send
    logic [NIBBLE_W-1:0] cur_nibble;

    // 0-9 map to digits and 10-15 to upper case letters
    function automatic logic [BYTE_W-1:0] hex_ascii(input logic [NIBBLE_W-1:0] nib);
        logic [BYTE_W-1:0] nib_ext;
        nib_ext = BYTE_W'(nib);
        if (nib < NIBBLE_W'(10)) begin
            return ASCII_ZERO + nib_ext;
        end
        return ASCII_A + nib_ext - BYTE_W'(10);
    endfunction

    // Sample capture and nibble shift
    always_ff @(posedge clk) begin
        if (update) begin
            sample_sr <= sample;
        end else if (char_take) begin
            sample_sr <= {sample_sr[SAMPLE_W-NIBBLE_W-1:0], {NIBBLE_W{1'b0}}};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            digit_cnt <= '0;
        end else if (update) begin
            digit_cnt <= CNT_W'(N_DIGITS);
        end else if (char_take && digit_cnt != '0) begin
            digit_cnt <= digit_cnt - 1'b1;
        end
    end

    assign cur_nibble = sample_sr[SAMPLE_W-1 -: NIBBLE_W];   // MS nibble first

    assign char_valid = (digit_cnt != '0);
    assign char_byte  = hex_ascii(cur_nibble);

endmodule

// ==== hw/lcd_cmd_seq.sv ====
`timescale 1ns/1ps

module lcd_cmd_seq (
    input  logic              clk,
    input  logic              rst,
    input  logic              update,
    input  logic              cmd_take,
    output logic              cmd_valid,
    output lcd_pkg::lcd_cmd_e cmd_byte
);

    import lcd_pkg::*;

    localparam int IDX_W = $clog2(N_INIT_CMDS + 1);

    logic [IDX_W-1:0] init_idx;     // Next init command or N_INIT_CMDS when done
    logic             init_done;
    logic             home_pend;    // Cursor home owed for an update
    lcd_cmd_e         init_cmd;

    assign init_done = (init_idx == IDX_W'(N_INIT_CMDS));

    // Init list in power-up order
    always_comb begin
        case (init_idx)
            IDX_W'(0): init_cmd = cmd_function_set;
            IDX_W'(1): init_cmd = cmd_display_on;
            IDX_W'(2): init_cmd = cmd_entry_mode;
            default:   init_cmd = cmd_clear;
        endcase
    end

    // Walk the init list, one step per written byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_idx <= '0;
        end else if (!init_done && cmd_take) begin
            init_idx <= init_idx + 1'b1;
        end
    end

    // Home request per frame
    // Only looked at once init is done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            home_pend <= 1'b0;
        end else if (update) begin
            home_pend <= 1'b1;
        end else if (init_done && cmd_take) begin
            home_pend <= 1'b0;
        end
    end

    // Init list pending out of reset, then one home per update
    always_comb begin
        if (init_done) begin
            cmd_valid = home_pend;
            cmd_byte  = cmd_home;
        end else begin
            cmd_valid = 1'b1;
            cmd_byte  = init_cmd;
        end
    end

endmodule

// ==== hw/lcd_pkg.sv ====
package lcd_pkg;

    // Bus and sample widths
    localparam int BYTE_W   = 8;
    localparam int NIBBLE_W = 4;
    localparam int SAMPLE_W = 16;   // ADC code width

    // One hex character per nibble of the sample
    localparam int N_DIGITS = SAMPLE_W / NIBBLE_W;

    // Function set, display on, entry mode, clear
    localparam int N_INIT_CMDS = 4;

    // ASCII bases for the hex digit rule
    localparam logic [BYTE_W-1:0] ASCII_ZERO = 8'h30;   // '0'
    localparam logic [BYTE_W-1:0] ASCII_A    = 8'h41;   // 'A'

    // HD44780 style instruction bytes
    typedef enum logic [BYTE_W-1:0] {
        cmd_clear        = 8'h01,   // Clear display
        cmd_home         = 8'h02,   // Cursor home
        cmd_entry_mode   = 8'h06,   // Increment, no shift
        cmd_display_on   = 8'h0C,   // Display on, cursor off
        cmd_function_set = 8'h38    // 8-bit bus, two lines
    } lcd_cmd_e;

    // Bus controller phases of one byte write
    typedef enum logic [2:0] {
        st_idle,        // Waiting for a stream
        st_wait_busy,   // LCD busy flag high
        st_setup,       // rs and data settle, e low
        st_pulse,       // e high
        st_hold         // e low again, take pulse
    } bus_state_e;

endpackage
